// ==== all.f ====
+incdir+include
verilog/alu_pkg.sv
verilog/alu_exec_if.sv
verilog/alu_cond_eval.sv
verilog/alu_decode.sv
verilog/alu_execute.sv
verilog/alu_result.sv
verilog/alu_top.sv
verification/tb_alu.sv

// ==== include/alu_config.svh ====
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_WIDTH     64
`define ALU_OP_BITS   4
`define ALU_COND_BITS 4

// opcode field
`define ALU_OP_ADD   4'd0
`define ALU_OP_SUB   4'd1
`define ALU_OP_AND   4'd2
`define ALU_OP_OR    4'd3
`define ALU_OP_XOR   4'd4
`define ALU_OP_MOV   4'd5
`define ALU_OP_ZXT8  4'd6
`define ALU_OP_ZXT16 4'd7
`define ALU_OP_SXT8  4'd8
`define ALU_OP_SXT16 4'd9
`define ALU_OP_SXT32 4'd10
`define ALU_OP_CMOV  4'd11
`define ALU_OP_CSET  4'd12

// result group select, decode to execute
`define ALU_SEL_BITS  2
`define ALU_SEL_ADDER 2'd0
`define ALU_SEL_LOGIC 2'd1
`define ALU_SEL_MOVE  2'd2
`define ALU_SEL_COND  2'd3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module tb_alu -o tb_alu \
  && ./obj_dir/tb_alu > sim.log 2>&1 \
  || echo "build or simulation returned an error"

[ -f sim.log ] && cat sim.log

grep -qx "Done: no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== verification/tb_alu.sv ====
`include "alu_config.svh"

module tb_alu;
  import alu_pkg::*;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0] res;
    alu_flags_t            flags;
    logic                  wr;
  } expect_t;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  alu_op_e               op;
  alu_size_e             size;
  alu_cond_e             cond;
  logic                  set_flags;
  logic [`ALU_WIDTH-1:0] a;
  logic [`ALU_WIDTH-1:0] b;
  alu_flags_t            flags_in;
  logic                  out_valid;
  logic [`ALU_WIDTH-1:0] res;
  alu_flags_t            flags_out;
  logic                  flags_wr;

  expect_t pending[$];
  expect_t last_exp;
  logic    have_last = 1'b0;
  logic    armed = 1'b0;
  logic    prev_valid = 1'b0;

  alu_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .size      (size),
    .cond      (cond),
    .set_flags (set_flags),
    .a         (a),
    .b         (b),
    .flags_in  (flags_in),
    .out_valid (out_valid),
    .res       (res),
    .flags_out (flags_out),
    .flags_wr  (flags_wr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // odd code negates the even one
  function automatic logic cond_holds(input alu_flags_t f, input alu_cond_e c);
    logic [3:0] code;
    logic       base;
    code = c;
    case (code[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.s;
      3'd2:    base = !f.c && !f.z;          // above
      3'd3:    base = !f.c;
      3'd4:    base = (f.s == f.o) && !f.z;  // greater
      3'd5:    base = (f.s == f.o);
      3'd6:    base = f.o;
      default: base = f.p;
    endcase
    return code[0] ? !base : base;
  endfunction

  function automatic expect_t alu_ref(input alu_op_e o, input alu_size_e s, input alu_cond_e c,
                                      input logic sf, input logic [63:0] x,
                                      input logic [63:0] y, input alu_flags_t f);
    expect_t     e;
    logic [63:0] mask;
    logic [63:0] xm;
    logic [63:0] ym;
    logic [63:0] r;
    logic [64:0] wide;
    int          top;
    logic        arith;
    logic        logical;
    logic        hold;
    mask = (s == size64) ? {64{1'b1}} : 64'h0000_0000_ffff_ffff;
    top = (s == size64) ? 63 : 31;
    xm = x & mask;
    ym = y & mask;
    hold = cond_holds(f, c);
    arith = 1'b0;
    logical = 1'b0;
    e.flags = f;
    case (o)
      op_add: begin
        wide = {1'b0, xm} + {1'b0, ym};
        r = wide[63:0] & mask;
        arith = 1'b1;
        e.flags.c = (s == size64) ? wide[64] : wide[32];
        e.flags.a = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
        e.flags.o = (x[top] == y[top]) && (r[top] != x[top]);
      end
      op_sub: begin
        r = (xm - ym) & mask;
        arith = 1'b1;
        e.flags.c = xm < ym; // borrow
        e.flags.a = x[3:0] < y[3:0];
        e.flags.o = (x[top] != y[top]) && (r[top] != x[top]);
      end
      op_and, op_or, op_xor: begin
        if (o == op_and)
          r = xm & ym;
        else if (o == op_or)
          r = xm | ym;
        else
          r = xm ^ ym;
        logical = 1'b1;
        e.flags.c = 1'b0;
        e.flags.o = 1'b0;
        e.flags.a = 1'b0;
      end
      op_mov:   r = ym;
      op_zxt8:  r = {56'b0, y[7:0]};
      op_zxt16: r = {48'b0, y[15:0]};
      op_sxt8:  r = {{56{y[7]}}, y[7:0]};
      op_sxt16: r = {{48{y[15]}}, y[15:0]};
      op_sxt32: r = {{32{y[31]}}, y[31:0]};
      op_cmov:  r = hold ? ym : xm;
      op_cset:  r = hold ? 64'd1 : 64'd0;
      default:  r = 64'd0;
    endcase
    if (arith || logical) begin
      e.flags.s = r[top];
      e.flags.z = (r == 64'd0);
      e.flags.p = ~^r[7:0];
    end
    e.res = r;
    e.wr = sf && (arith || logical);
    return e;
  endfunction

  function automatic logic [63:0] edge_value(input int idx);
    case (idx)
      0:       return 64'h0000_0000_0000_0000;
      1:       return 64'hffff_ffff_ffff_ffff;
      2:       return 64'h8000_0000_0000_0000;
      3:       return 64'h7fff_ffff_ffff_ffff;
      4:       return 64'h0000_0000_8000_0000;
      5:       return 64'h0000_0000_7fff_ffff;
      6:       return 64'h0000_0000_ffff_ffff;
      default: return 64'h0000_0000_0000_0001;
    endcase
  endfunction

  function automatic logic [63:0] pick_operand();
    if ($urandom_range(0, 3) == 0)
      return edge_value(int'($urandom_range(0, 7)));
    return {$urandom, $urandom};
  endfunction

  function automatic alu_flags_t random_flags();
    return alu_flags_t'(6'($urandom));
  endfunction

  task automatic drive(input logic v, input alu_op_e o, input alu_size_e s, input alu_cond_e c,
                       input logic sf, input logic [63:0] x, input logic [63:0] y,
                       input alu_flags_t f);
    @(negedge clk);
    in_valid  = v;
    op        = o;
    size      = s;
    cond      = c;
    set_flags = sf;
    a         = x;
    b         = y;
    flags_in  = f;
  endtask

  task automatic send_random();
    drive($urandom_range(0, 3) != 0, alu_op_e'(4'($urandom_range(0, 12))),
          alu_size_e'(1'($urandom)), alu_cond_e'(4'($urandom)), 1'($urandom),
          pick_operand(), pick_operand(), random_flags());
  endtask

  // outputs read here still hold the previous cycle's register values
  always @(posedge clk) begin
    expect_t exp_r;
    if (armed) begin
      check("out_valid", 64'(out_valid), 64'(prev_valid));
      if (out_valid) begin
        if (pending.size() == 0) begin
          $display("result came out with no operation outstanding");
          stop_run();
        end else begin
          exp_r = pending.pop_front();
          check("res", res, exp_r.res);
          check("flags_out", 64'(flags_out), 64'(exp_r.flags));
          check("flags_wr", 64'(flags_wr), 64'(exp_r.wr));
          last_exp = exp_r;
          have_last = 1'b1;
        end
      end else if (have_last) begin
        check("res", res, last_exp.res); // held while idle
        check("flags_out", 64'(flags_out), 64'(last_exp.flags));
        check("flags_wr", 64'(flags_wr), 64'(last_exp.wr));
      end else begin
        check("flags_wr", 64'(flags_wr), 64'd0);
      end
    end
    if (!rst && in_valid)
      pending.push_back(alu_ref(op, size, cond, set_flags, a, b, flags_in));
    prev_valid = !rst && in_valid;
    if (rst)
      armed = 1'b1;
  end

  initial begin
    int waited;
    void'($urandom(32'h680412fe));
    rst       = 1'b1;
    in_valid  = 1'b1; // offered during reset, never accepted
    op        = op_add;
    size      = size64;
    cond      = cond_z;
    set_flags = 1'b1;
    a         = '0;
    b         = '0;
    flags_in  = '0;
    repeat (8) @(negedge clk);
    rst      = 1'b0;
    in_valid = 1'b0;

    // add and sub over all edge operand pairs
    for (int o = 0; o < 2; o++)
      for (int s = 0; s < 2; s++)
        for (int i = 0; i < 8; i++)
          for (int j = 0; j < 8; j++)
            drive(1'b1, alu_op_e'(4'(o)), alu_size_e'(1'(s)), cond_z, 1'b1,
                  edge_value(i), edge_value(j), random_flags());

    for (int c = 0; c < 16; c++)
      for (int k = 0; k < 4; k++) begin
        drive(1'b1, op_cmov, alu_size_e'(1'($urandom)), alu_cond_e'(4'(c)), 1'($urandom),
              pick_operand(), pick_operand(), random_flags());
        drive(1'b1, op_cset, alu_size_e'(1'($urandom)), alu_cond_e'(4'(c)), 1'($urandom),
              pick_operand(), pick_operand(), random_flags());
      end

    // mov and the extensions
    for (int o = 5; o <= 10; o++)
      for (int k = 0; k < 8; k++)
        drive(1'b1, alu_op_e'(4'(o)), alu_size_e'(1'(k)), cond_z, 1'($urandom),
              pick_operand(), pick_operand(), random_flags());

    repeat (2000) send_random();
    drive(1'b0, op_add, size64, cond_z, 1'b0, '0, '0, '0);

    waited = 0;
    while (pending.size() != 0 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      $display("timed out waiting for the last results to come out");
      stop_run();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== verilog/alu_cond_eval.sv ====
module alu_cond_eval (
  input  alu_pkg::alu_flags_t flags,
  input  alu_pkg::alu_cond_e  cond,
  output logic                hold
);
  import alu_pkg::*;

  logic lt; // signed less than

  assign lt = flags.s ^ flags.o;

  always_comb begin
    hold = 1'b0;
    case (cond)
      cond_z:   hold = flags.z;
      cond_nz:  hold = ~flags.z;
      cond_s:   hold = flags.s;
      cond_ns:  hold = ~flags.s;
      cond_ugt: hold = ~(flags.c | flags.z);
      cond_ule: hold = flags.c | flags.z;
      cond_uge: hold = ~flags.c;
      cond_ult: hold = flags.c;
      cond_sgt: hold = ~(lt | flags.z);
      cond_sle: hold = lt | flags.z;
      cond_sge: hold = ~lt;
      cond_slt: hold = lt;
      cond_o:   hold = flags.o;
      cond_no:  hold = ~flags.o;
      cond_p:   hold = flags.p;
      cond_np:  hold = ~flags.p;
    endcase
  end

endmodule

// ==== verilog/alu_decode.sv ====
`include "alu_config.svh"

module alu_decode (
  input  alu_pkg::alu_op_e          op,
  input  alu_pkg::alu_cond_e        cond,
  input  alu_pkg::alu_flags_t       flags_in,
  output logic                      is_sub,
  output logic [`ALU_SEL_BITS-1:0]  sel_op,
  output logic                      take,
  output alu_pkg::alu_flag_class_e  flag_class
);
  import alu_pkg::*;

  logic hold;

  alu_cond_eval u_cond (
    .flags (flags_in),
    .cond  (cond),
    .hold  (hold)
  );

  always_comb begin
    is_sub     = 1'b0;
    sel_op     = `ALU_SEL_MOVE;
    flag_class = flag_none;
    case (op)
      op_add: begin
        sel_op     = `ALU_SEL_ADDER;
        flag_class = flag_arith;
      end
      op_sub: begin
        is_sub     = 1'b1; // adder takes ~b + 1
        sel_op     = `ALU_SEL_ADDER;
        flag_class = flag_arith;
      end
      op_and, op_or, op_xor: begin
        sel_op     = `ALU_SEL_LOGIC;
        flag_class = flag_logic;
      end
      op_cmov, op_cset: begin
        sel_op = `ALU_SEL_COND;
      end
      default: begin
        sel_op = `ALU_SEL_MOVE; // mov and extensions
      end
    endcase
  end

  // resolved condition, only the cond group reads it
  assign take = hold;

endmodule

// ==== verilog/alu_exec_if.sv ====
`include "alu_config.svh"

interface alu_exec_if;
  import alu_pkg::*;

  logic                  valid;
  logic [`ALU_WIDTH-1:0] data;
  logic                  carry;      // out of bit 31 or 63, not yet inverted for sub
  logic                  half_carry;
  logic                  a_msb;
  logic                  b_msb;
  logic                  is_sub;
  alu_size_e             size;
  alu_flag_class_e       flag_class;
  logic                  set_flags;
  alu_flags_t            flags_in;

  modport exec (
    output valid, data, carry, half_carry, a_msb, b_msb, is_sub,
    output size, flag_class, set_flags, flags_in
  );

  modport res (
    input valid, data, carry, half_carry, a_msb, b_msb, is_sub,
    input size, flag_class, set_flags, flags_in
  );

endinterface

// ==== verilog/alu_execute.sv ====
`include "alu_config.svh"

module alu_execute (
  input  logic                      in_valid,
  input  alu_pkg::alu_op_e          op,
  input  alu_pkg::alu_size_e        size,
  input  logic                      set_flags,
  input  logic [`ALU_WIDTH-1:0]     a,
  input  logic [`ALU_WIDTH-1:0]     b,
  input  alu_pkg::alu_flags_t       flags_in,
  input  logic                      is_sub,
  input  logic [`ALU_SEL_BITS-1:0]  sel_op,
  input  logic                      take,
  input  alu_pkg::alu_flag_class_e  flag_class,
  alu_exec_if.exec                  ex
);
  import alu_pkg::*;

  logic [`ALU_WIDTH-1:0] b_add;
  logic [`ALU_WIDTH:0]   sum;
  logic                  c3;
  logic                  c31;
  logic                  c63;
  logic [`ALU_WIDTH-1:0] logic_res;
  logic [`ALU_WIDTH-1:0] move_res;
  logic [`ALU_WIDTH-1:0] cond_res;
  logic [`ALU_WIDTH-1:0] full_res;
  logic                  is_ext;

  // one shared adder, sub as a + ~b + 1
  assign b_add = is_sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_add} + {{`ALU_WIDTH{1'b0}}, is_sub};

  // carry into bit n recovered from the sum bit
  assign c3  = a[4] ^ b_add[4] ^ sum[4];
  assign c31 = a[32] ^ b_add[32] ^ sum[32];
  assign c63 = sum[`ALU_WIDTH];

  always_comb begin
    case (op)
      op_and:  logic_res = a & b;
      op_or:   logic_res = a | b;
      default: logic_res = a ^ b;
    endcase
  end

  always_comb begin
    case (op)
      op_zxt8:  move_res = {{(`ALU_WIDTH-8){1'b0}}, b[7:0]};
      op_zxt16: move_res = {{(`ALU_WIDTH-16){1'b0}}, b[15:0]};
      op_sxt8:  move_res = {{(`ALU_WIDTH-8){b[7]}}, b[7:0]};
      op_sxt16: move_res = {{(`ALU_WIDTH-16){b[15]}}, b[15:0]};
      op_sxt32: move_res = {{(`ALU_WIDTH-32){b[31]}}, b[31:0]};
      default:  move_res = b; // plain mov
    endcase
  end

  assign is_ext = op inside {op_zxt8, op_zxt16, op_sxt8, op_sxt16, op_sxt32};

  assign cond_res = (op == op_cset) ? {{(`ALU_WIDTH-1){1'b0}}, take} :
                    take            ? b : a;

  always_comb begin
    case (sel_op)
      `ALU_SEL_ADDER: full_res = sum[`ALU_WIDTH-1:0];
      `ALU_SEL_LOGIC: full_res = logic_res;
      `ALU_SEL_COND:  full_res = cond_res;
      default:        full_res = move_res;
    endcase
  end

  // extensions always write all 64 bits
  assign ex.data = (size == size32 && !is_ext) ?
                   {{(`ALU_WIDTH-32){1'b0}}, full_res[31:0]} : full_res;

  assign ex.valid      = in_valid;
  assign ex.carry      = (size == size64) ? c63 : c31;
  assign ex.half_carry = c3;
  assign ex.a_msb      = (size == size64) ? a[`ALU_WIDTH-1] : a[31];
  assign ex.b_msb      = (size == size64) ? b[`ALU_WIDTH-1] : b[31]; // raw b, not inverted
  assign ex.is_sub     = is_sub;
  assign ex.size       = size;
  assign ex.flag_class = flag_class;
  assign ex.set_flags  = set_flags;
  assign ex.flags_in   = flags_in;

endmodule

// ==== verilog/alu_pkg.sv ====
`include "alu_config.svh"

package alu_pkg;

  typedef enum logic [`ALU_OP_BITS-1:0] {
    op_add   = `ALU_OP_ADD,
    op_sub   = `ALU_OP_SUB,
    op_and   = `ALU_OP_AND,
    op_or    = `ALU_OP_OR,
    op_xor   = `ALU_OP_XOR,
    op_mov   = `ALU_OP_MOV,
    op_zxt8  = `ALU_OP_ZXT8,
    op_zxt16 = `ALU_OP_ZXT16,
    op_sxt8  = `ALU_OP_SXT8,
    op_sxt16 = `ALU_OP_SXT16,
    op_sxt32 = `ALU_OP_SXT32,
    op_cmov  = `ALU_OP_CMOV,
    op_cset  = `ALU_OP_CSET
  } alu_op_e;

  // width for S, Z and C
  typedef enum logic {size32, size64} alu_size_e;

  // x86 condition codes, odd code is the negation
  typedef enum logic [`ALU_COND_BITS-1:0] {
    cond_z,   cond_nz,
    cond_s,   cond_ns,
    cond_ugt, cond_ule,
    cond_uge, cond_ult,
    cond_sgt, cond_sle,
    cond_sge, cond_slt,
    cond_o,   cond_no,
    cond_p,   cond_np
  } alu_cond_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } alu_flags_t;

  typedef enum logic [1:0] {flag_none, flag_arith, flag_logic} alu_flag_class_e;

endpackage

// ==== verilog/alu_result.sv ====
`include "alu_config.svh"

module alu_result (
  input  logic                  clk,
  input  logic                  rst,
  alu_exec_if.res               ex,
  output logic                  out_valid,
  output logic [`ALU_WIDTH-1:0] res,
  output alu_pkg::alu_flags_t   flags_out,
  output logic                  flags_wr
);
  import alu_pkg::*;

  logic            carry_q;
  logic            half_q;
  logic            a_msb_q;
  logic            b_msb_q;
  logic            is_sub_q;
  alu_size_e       size_q;
  alu_flag_class_e class_q;
  alu_flags_t      flags_in_q;

  logic msb;
  logic zero;
  logic par;
  logic b_eff;
  logic ovf;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      flags_wr  <= 1'b0;
    end else begin
      out_valid <= ex.valid;
      if (ex.valid)
        flags_wr <= ex.set_flags && (ex.flag_class != flag_none);
    end
  end

  // payload, held while idle
  always_ff @(posedge clk) begin
    if (ex.valid) begin
      res        <= ex.data;
      carry_q    <= ex.carry;
      half_q     <= ex.half_carry;
      a_msb_q    <= ex.a_msb;
      b_msb_q    <= ex.b_msb;
      is_sub_q   <= ex.is_sub;
      size_q     <= ex.size;
      class_q    <= ex.flag_class;
      flags_in_q <= ex.flags_in;
    end
  end

  assign msb  = (size_q == size64) ? res[`ALU_WIDTH-1] : res[31];
  assign zero = (size_q == size64) ? (res == '0) : (res[31:0] == 32'b0);
  assign par  = ~^res[7:0]; // even parity of low byte

  // overflow when operands agree in sign and the result does not
  assign b_eff = b_msb_q ^ is_sub_q;
  assign ovf   = (a_msb_q == b_eff) && (msb != a_msb_q);

  always_comb begin
    case (class_q)
      flag_arith: begin
        flags_out.c = carry_q ^ is_sub_q; // borrow for sub
        flags_out.o = ovf;
        flags_out.a = half_q ^ is_sub_q;
        flags_out.s = msb;
        flags_out.z = zero;
        flags_out.p = par;
      end
      flag_logic: begin
        flags_out.c = 1'b0;
        flags_out.o = 1'b0;
        flags_out.a = 1'b0;
        flags_out.s = msb;
        flags_out.z = zero;
        flags_out.p = par;
      end
      default: begin
        flags_out = flags_in_q;
      end
    endcase
  end

endmodule

// ==== verilog/alu_top.sv ====
`include "alu_config.svh"

module alu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  alu_pkg::alu_op_e      op,
  input  alu_pkg::alu_size_e    size,
  input  alu_pkg::alu_cond_e    cond,
  input  logic                  set_flags,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  alu_pkg::alu_flags_t   flags_in,
  output logic                  out_valid,
  output logic [`ALU_WIDTH-1:0] res,
  output alu_pkg::alu_flags_t   flags_out,
  output logic                  flags_wr
);
  import alu_pkg::*;

  logic                     is_sub;
  logic [`ALU_SEL_BITS-1:0] sel_op;
  logic                     take;
  alu_flag_class_e          flag_class;

  alu_exec_if ex_if ();

  alu_decode u_decode (
    .op         (op),
    .cond       (cond),
    .flags_in   (flags_in),
    .is_sub     (is_sub),
    .sel_op     (sel_op),
    .take       (take),
    .flag_class (flag_class)
  );

  alu_execute u_execute (
    .in_valid   (in_valid),
    .op         (op),
    .size       (size),
    .set_flags  (set_flags),
    .a          (a),
    .b          (b),
    .flags_in   (flags_in),
    .is_sub     (is_sub),
    .sel_op     (sel_op),
    .take       (take),
    .flag_class (flag_class),
    .ex         (ex_if.exec)
  );

  alu_result u_result (
    .clk       (clk),
    .rst       (rst),
    .ex        (ex_if.res),
    .out_valid (out_valid),
    .res       (res),
    .flags_out (flags_out),
    .flags_wr  (flags_wr)
  );

endmodule
